/* hw/fft_consts.svh */
// Fixed widths of the byte-window FFT pipeline.
// Include wherever a width or the window length is needed; the package
// builds its typedefs from these values.

`ifndef FFT_CONSTS_SVH
`define FFT_CONSTS_SVH

// Bytes held in the shifting window
`define FFT_WINDOW_LEN 8

// One input byte
`define FFT_SAMPLE_W 8

// Product of two window bytes
`define FFT_PROD_W 16

// Sum of four products with headroom
`define FFT_SUM_W 18

// Running accumulator, wraps modulo 2^24
`define FFT_ACC_W 24

`endif

/* hw/fft_pkg.sv */
// Shared types of the byte-window FFT pipeline.
// Stage records travel between modules as the packed structs below.
// Modules import this package inside their bodies.

`default_nettype none

package fft_pkg;

  `include "fft_consts.svh"

  typedef logic [`FFT_SAMPLE_W-1:0] sample_t;
  typedef logic [7:0]               seq_t;  // Accepted-sample count, wraps
  typedef logic [`FFT_PROD_W-1:0]   prod_t;
  typedef logic [`FFT_SUM_W-1:0]    sum_t;
  typedef logic signed [`FFT_SUM_W-1:0] diff_t;  // Alternating sum may go negative
  typedef logic [`FFT_ACC_W-1:0]    acc_t;

  typedef struct packed {
    logic                                valid;
    sample_t [`FFT_WINDOW_LEN-1:0]       lanes;   // Lane 0 is the newest byte
    sample_t                             sample;
    seq_t                                seq;
  } window_rec_t;

  typedef struct packed {
    logic    valid;
    sum_t    sum;
    diff_t   diff;
    sample_t sample;
    seq_t    seq;
  } product_rec_t;

  // Finished record, also the top-level output
  typedef struct packed {
    sum_t    sum;
    diff_t   diff;
    acc_t    acc;
    sample_t mix;
  } result_rec_t;

  typedef enum logic [1:0] {
    SEND_IDLE,
    SEND_REQ,
    SEND_WAIT_ACK_LOW
  } send_state_t;

endpackage

`default_nettype wire

/* hw/sample_window.sv */
// Input stage of the FFT pipeline.
// Accepts one byte per four-phase req/ack exchange, shifts it into the
// eight-byte window and emits a window record. Ack is only granted when
// the output slot is empty or is being taken on the same edge.

`timescale 1ns/1ns
`include "fft_consts.svh"
`default_nettype none

module sample_window (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                in_req,
  input  fft_pkg::sample_t    in_sample,
  output logic                in_ack,
  input  logic                win_ready,
  output fft_pkg::window_rec_t win_rec
);

  import fft_pkg::*;

  logic room;
  logic accept;

  // Slot is free, or the next stage takes the record this cycle
  assign room   = !win_rec.valid || win_ready;
  assign accept = in_req && !in_ack && room;

  // Input handshake
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_ack <= 1'b0;
    end else if (accept) begin
      in_ack <= 1'b1;
    end else if (!in_req) begin
      in_ack <= 1'b0;  // Return to zero once req has dropped
    end
  end

  // Window, sample count and the outgoing record.
  // The lanes double as the window storage, so they only move on accept
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      win_rec <= '0;
    end else if (accept) begin
      win_rec.valid  <= 1'b1;
      win_rec.lanes  <= {win_rec.lanes[`FFT_WINDOW_LEN-2:0], in_sample};
      win_rec.sample <= in_sample;
      win_rec.seq    <= win_rec.seq + seq_t'(1);  // First sample gets 1
    end else if (win_ready) begin
      win_rec.valid <= 1'b0;  // Record taken, nothing new
    end
  end

endmodule

`default_nettype wire

/* hw/pair_product.sv */
// Product stage of the FFT pipeline.
// Multiplies neighbouring window lanes in pairs (0,1), (2,3), (4,5), (6,7)
// and registers both the plain total (FFT-like) and the alternating
// signed total (DCT-like). Sample and seq pass along unchanged.

`timescale 1ns/1ns
`include "fft_consts.svh"
`default_nettype none

module pair_product (
  input  logic                  clk,
  input  logic                  rst_n,
  input  fft_pkg::window_rec_t  win_rec,
  output logic                  win_ready,
  input  logic                  prod_ready,
  output fft_pkg::product_rec_t prod_rec
);

  import fft_pkg::*;

  prod_t prods [`FFT_WINDOW_LEN/2];
  sum_t  sum_next;
  diff_t diff_next;
  logic  load;

  // Empty slot or record leaving this cycle
  assign win_ready = !prod_rec.valid || prod_ready;
  assign load      = win_rec.valid && win_ready;

  always_comb begin
    sum_next  = '0;
    diff_next = '0;
    for (int k = 0; k < `FFT_WINDOW_LEN/2; k++) begin
      prods[k] = win_rec.lanes[2*k] * win_rec.lanes[2*k+1];
      sum_next = sum_next + sum_t'(prods[k]);
      // Even pairs add, odd pairs subtract
      if (k % 2 == 0) begin
        diff_next = diff_next + diff_t'(prods[k]);
      end else begin
        diff_next = diff_next - diff_t'(prods[k]);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prod_rec <= '0;
    end else if (win_ready) begin
      prod_rec.valid <= win_rec.valid;
      if (load) begin
        prod_rec.sum    <= sum_next;
        prod_rec.diff   <= diff_next;
        prod_rec.sample <= win_rec.sample;
        prod_rec.seq    <= win_rec.seq;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/running_accum.sv */
// Accumulator stage of the FFT pipeline.
// Adds every plain sum into a wrapping 24-bit total and forms the mix byte
// from the low accumulator byte, the square-xor-self lookup of the sample
// and the sample count. Holds the finished record until it is taken.

`timescale 1ns/1ns
`include "fft_consts.svh"
`default_nettype none

module running_accum (
  input  logic                  clk,
  input  logic                  rst_n,
  input  fft_pkg::product_rec_t prod_rec,
  output logic                  prod_ready,
  input  logic                  acc_ready,
  output logic                  acc_valid,
  output fft_pkg::result_rec_t  acc_rec
);

  import fft_pkg::*;

  // Low byte of s ^ s*s, the fixed lookup table as a formula
  function automatic sample_t square_xor_self(input sample_t s);
    prod_t sq;
    sq = s * s;
    return s ^ sq[`FFT_SAMPLE_W-1:0];
  endfunction

  acc_t    acc_next;
  sample_t mix_next;
  logic    load;

  assign prod_ready = !acc_valid || acc_ready;
  assign load       = prod_rec.valid && prod_ready;

  // acc_rec.acc is the running total itself
  assign acc_next = acc_rec.acc + acc_t'(prod_rec.sum);
  assign mix_next = acc_next[`FFT_SAMPLE_W-1:0]
                  ^ square_xor_self(prod_rec.sample)
                  ^ prod_rec.seq;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_valid <= 1'b0;
      acc_rec   <= '0;
    end else if (prod_ready) begin
      acc_valid <= prod_rec.valid;
      if (load) begin
        acc_rec.sum  <= prod_rec.sum;
        acc_rec.diff <= prod_rec.diff;
        acc_rec.acc  <= acc_next;  // Wraps modulo 2^24
        acc_rec.mix  <= mix_next;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/result_port.sv */
// Output stage of the FFT pipeline.
// Captures one finished record and offers it over a four-phase req/ack
// port. The record and req stay put until ack is seen; a new record is
// only taken after ack has returned low.

`timescale 1ns/1ns
`default_nettype none

module result_port (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 acc_valid,
  input  fft_pkg::result_rec_t acc_rec,
  output logic                 acc_ready,
  output logic                 out_req,
  input  logic                 out_ack,
  output fft_pkg::result_rec_t out_result
);

  import fft_pkg::*;

  send_state_t state;

  assign acc_ready = (state == SEND_IDLE);
  assign out_req   = (state == SEND_REQ);  // High from the capture edge on

  // Handshake FSM
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= SEND_IDLE;
    end else begin
      case (state)
        SEND_IDLE: begin
          if (acc_valid) begin
            state <= SEND_REQ;
          end
        end
        SEND_REQ: begin
          if (out_ack) begin
            state <= SEND_WAIT_ACK_LOW;  // Drop req
          end
        end
        SEND_WAIT_ACK_LOW: begin
          if (!out_ack) begin
            state <= SEND_IDLE;
          end
        end
        default: state <= SEND_IDLE;
      endcase
    end
  end

  // Held record, only written while idle
  always_ff @(posedge clk) begin
    if (acc_ready && acc_valid) begin
      out_result <= acc_rec;
    end
  end

endmodule

`default_nettype wire

/* hw/fft_pipeline_top.sv */
// Top level of the byte-window FFT pipeline.
// Bytes enter over a four-phase req/ack port and each one leaves as a
// result record over a second four-phase port. Three cycles from in_ack
// to out_req when the output is not stalled.

`timescale 1ns/1ns
`default_nettype none

module fft_pipeline_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 in_req,
  input  fft_pkg::sample_t     in_sample,
  output logic                 in_ack,
  output logic                 out_req,
  input  logic                 out_ack,
  output fft_pkg::result_rec_t out_result
);

  import fft_pkg::*;

  window_rec_t  win_rec;
  logic         win_ready;
  product_rec_t prod_rec;
  logic         prod_ready;
  result_rec_t  acc_rec;
  logic         acc_valid;
  logic         acc_ready;

  sample_window sample_window_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_req    (in_req),
    .in_sample (in_sample),
    .in_ack    (in_ack),
    .win_ready (win_ready),
    .win_rec   (win_rec)
  );

  pair_product pair_product_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .win_rec    (win_rec),
    .win_ready  (win_ready),
    .prod_ready (prod_ready),
    .prod_rec   (prod_rec)
  );

  running_accum running_accum_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .prod_rec   (prod_rec),
    .prod_ready (prod_ready),
    .acc_ready  (acc_ready),
    .acc_valid  (acc_valid),
    .acc_rec    (acc_rec)
  );

  result_port result_port_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .acc_valid  (acc_valid),
    .acc_rec    (acc_rec),
    .acc_ready  (acc_ready),
    .out_req    (out_req),
    .out_ack    (out_ack),
    .out_result (out_result)
  );

endmodule

`default_nettype wire

/* verification/fft_pipeline_assertions.sv */
// Handshake checks for the FFT pipeline top level.
// Bound onto every fft_pipeline_top instance by the bind statement below,
// so the testbench needs no extra wiring.

`timescale 1ns/1ns
`default_nettype none

module fft_pipeline_assertions (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 in_req,
  input logic                 in_ack,
  input logic                 out_req,
  input logic                 out_ack,
  input fft_pkg::result_rec_t out_result
);

  // Ack answers a request seen on the edge before
  in_ack_needs_req: assert property (
    @(posedge clk) disable iff (!rst_n) $rose(in_ack) |-> $past(in_req)
  ) else $error("in_ack rose without a pending in_req");

  // Offered record must not move before it is acknowledged
  out_result_held: assert property (
    @(posedge clk) disable iff (!rst_n) (out_req && !out_ack) |=> $stable(out_result)
  ) else $error("out_result changed while waiting for out_ack");

  out_req_held: assert property (
    @(posedge clk) disable iff (!rst_n) (out_req && !out_ack) |=> out_req
  ) else $error("out_req dropped before out_ack");

  // New offer only once ack has returned low
  out_req_after_ack_low: assert property (
    @(posedge clk) disable iff (!rst_n) $rose(out_req) |-> !out_ack
  ) else $error("out_req rose while out_ack was still high");

  handshakes_idle_in_reset: assert property (
    @(posedge clk) !rst_n |-> (!in_ack && !out_req)
  ) else $error("in_ack or out_req high during reset");

endmodule

bind fft_pipeline_top fft_pipeline_assertions assertions_i (
  .clk        (clk),
  .rst_n      (rst_n),
  .in_req     (in_req),
  .in_ack     (in_ack),
  .out_req    (out_req),
  .out_ack    (out_ack),
  .out_result (out_result)
);

`default_nettype wire

/* verification/fft_pipeline_tb.sv */
// Testbench for the byte-window FFT pipeline.
// A table of sample bytes and out_ack delays is replayed several times over
// the input handshake. A second process collects every result record in
// order and compares it with a reference model built from the pipeline rules.

`timescale 1ns/1ns
`include "fft_consts.svh"
`default_nettype none

module fft_pipeline_tb;

  import fft_pkg::*;

  localparam int NUM_ENTRIES     = 24;
  localparam int NUM_PASSES      = 12;  // 288 samples, so seq wraps
  localparam int TOTAL           = NUM_ENTRIES * NUM_PASSES;
  localparam int MAX_ACK_DELAY   = 6;
  localparam int WATCHDOG_CYCLES = TOTAL * (MAX_ACK_DELAY + 12) + 20;

  typedef struct packed {
    sample_t    sample;
    logic [3:0] ack_delay;  // Cycles before out_ack rises
  } stim_t;

  logic        clk;
  logic        rst_n;
  logic        in_req;
  sample_t     in_sample;
  logic        in_ack;
  logic        out_req;
  logic        out_ack;
  result_rec_t out_result;

  stim_t       stim_table [NUM_ENTRIES];
  result_rec_t expected [TOTAL];
  int          seed;
  int          results_seen;

  fft_pipeline_top dut_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_req     (in_req),
    .in_sample  (in_sample),
    .in_ack     (in_ack),
    .out_req    (out_req),
    .out_ack    (out_ack),
    .out_result (out_result)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic fail_value(input string msg);
    $display("Fail at %0t ns: %s", $time, msg);
    abort_run();
  endtask

  task automatic compare_sum(input sum_t got, input sum_t want, input int idx);
    if (got !== want) begin
      fail_value($sformatf("record %0d sum is %0d, expected %0d", idx, got, want));
    end
  endtask

  task automatic compare_diff(input diff_t got, input diff_t want, input int idx);
    if (got !== want) begin
      fail_value($sformatf("record %0d diff is %0d, expected %0d", idx, got, want));
    end
  endtask

  task automatic compare_acc(input acc_t got, input acc_t want, input int idx);
    if (got !== want) begin
      fail_value($sformatf("record %0d acc is %h, expected %h", idx, got, want));
    end
  endtask

  task automatic compare_mix(input sample_t got, input sample_t want, input int idx);
    if (got !== want) begin
      fail_value($sformatf("record %0d mix is %h, expected %h", idx, got, want));
    end
  endtask

  task automatic fill_table();
    int i;
    for (i = 0; i < NUM_ENTRIES; i++) begin
      stim_table[i].sample    = sample_t'($random(seed));
      stim_table[i].ack_delay = 4'($unsigned($random(seed)) % (MAX_ACK_DELAY + 1));
    end
    // Edge values first, then a run of 255 that fills whole windows
    stim_table[0].sample = 8'd0;
    stim_table[1].sample = 8'd255;
    stim_table[2].sample = 8'd1;
    for (i = 6; i < 18; i++) begin
      stim_table[i].sample = 8'd255;
    end
  endtask

  // Reference model of window, pair products, accumulator and mix
  task automatic build_expected();
    int win [`FFT_WINDOW_LEN];
    int prod [`FFT_WINDOW_LEN/2];
    int i;
    int k;
    int s;
    int sum_model;
    int diff_model;
    int acc_model;
    int seq_model;
    int mix_model;
    acc_model = 0;
    for (k = 0; k < `FFT_WINDOW_LEN; k++) begin
      win[k] = 0;
    end
    for (i = 0; i < TOTAL; i++) begin
      s = int'(stim_table[i % NUM_ENTRIES].sample);
      for (k = `FFT_WINDOW_LEN - 1; k > 0; k--) begin
        win[k] = win[k-1];
      end
      win[0] = s;
      for (k = 0; k < `FFT_WINDOW_LEN/2; k++) begin
        prod[k] = win[2*k] * win[2*k+1];
      end
      sum_model  = prod[0] + prod[1] + prod[2] + prod[3];
      diff_model = prod[0] - prod[1] + prod[2] - prod[3];
      acc_model  = (acc_model + sum_model) % (1 << 24);
      seq_model  = (i + 1) % 256;
      mix_model  = (acc_model % 256) ^ s ^ ((s * s) % 256) ^ seq_model;
      expected[i].sum  = sum_t'(sum_model);
      expected[i].diff = diff_t'(diff_model);
      expected[i].acc  = acc_t'(acc_model);
      expected[i].mix  = sample_t'(mix_model);
    end
  endtask

  task automatic drive_samples();
    int i;
    for (i = 0; i < TOTAL; i++) begin
      in_sample <= stim_table[i % NUM_ENTRIES].sample;
      in_req    <= 1'b1;
      @(posedge clk);
      while (!in_ack) @(posedge clk);  // Sample stays put until ack
      in_req <= 1'b0;
      @(posedge clk);
      while (in_ack) @(posedge clk);
    end
  endtask

  task automatic collect_results();
    int i;
    for (i = 0; i < TOTAL; i++) begin
      @(posedge clk);
      while (!out_req) @(posedge clk);
      compare_sum(out_result.sum, expected[i].sum, i);
      compare_diff(out_result.diff, expected[i].diff, i);
      compare_acc(out_result.acc, expected[i].acc, i);
      compare_mix(out_result.mix, expected[i].mix, i);
      results_seen++;
      repeat (int'(stim_table[i % NUM_ENTRIES].ack_delay)) @(posedge clk);
      out_ack <= 1'b1;
      @(posedge clk);
      while (out_req) @(posedge clk);
      out_ack <= 1'b0;
    end
  endtask

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: %0d clock periods passed with %0d of %0d results received",
             WATCHDOG_CYCLES, results_seen, TOTAL);
    abort_run();
  end

  initial begin : main
    seed         = 88896;
    results_seen = 0;
    rst_n        = 1'b0;
    in_req       = 1'b0;
    in_sample    = '0;
    out_ack      = 1'b0;
    fill_table();
    build_expected();
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    if (in_ack !== 1'b0 || out_req !== 1'b0) begin
      fail_value("in_ack or out_req not low after reset");
    end
    fork
      drive_samples();
      collect_results();
    join
    repeat (20) @(posedge clk);  // An extra record would raise out_req here
    if (out_req === 1'b0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("More result records than the %0d samples sent", TOTAL);
      abort_run();
    end
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+hw
hw/fft_pkg.sv
hw/sample_window.sv
hw/pair_product.sv
hw/running_accum.sv
hw/result_port.sv
hw/fft_pipeline_top.sv
verification/fft_pipeline_assertions.sv
verification/fft_pipeline_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the FFT pipeline testbench with Verilator, then judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module fft_pipeline_tb \
  -f vlog.f -o fft_pipeline_sim > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/fft_pipeline_sim > sim.log 2>&1
cat sim.log

grep -q "FAIL: see errors above" sim.log && { echo "Simulation reported errors"; exit 1; }
grep -q "PASS: all tests" sim.log || { echo "Simulation ended without passing"; exit 1; }
exit 0
